// File: source/phy_mgmt_pkg.sv
// management bus package
// bus widths, slave select and register maps of the phy management port
`default_nettype none

package phy_mgmt_pkg;

	////////////////////
	// bus geometry
	////////////////////
	localparam int MGMT_ADDR_W  = 9;	// word address on the top port
	localparam int SLAVE_ADDR_W = 8;	// word address inside a slave
	localparam int MGMT_DATA_W  = 32;
	localparam int SEL_BIT      = 8;	// set selects the reconfig slave

	localparam logic [MGMT_DATA_W-1:0] PHY_ID = 32'h0A10_6B52;	// fixed id word

	////////////////////
	// status csr map
	////////////////////
	typedef enum logic [SLAVE_ADDR_W-1:0] {
		CSR_ID         = 8'd0,	// read only
		CSR_BLOCK_LOCK = 8'd1,	// per channel, synced
		CSR_DATA_READY = 8'd2,	// per channel, synced
		CSR_HI_BER     = 8'd3,	// latched, clear on read
		CSR_CONTROL    = 8'd4,	// digital reset controls
		CSR_SUMMARY    = 8'd5	// pll lock and ready flags
	} csr_reg_e;

	localparam int CTRL_RX_RESET_LSB = 8;	// rx resets start here, tx reset is bit 0

	////////////////////
	// reconfig map
	////////////////////
	typedef enum logic [SLAVE_ADDR_W-1:0] {
		RC_CHANNEL = 8'd0,	// target channel
		RC_VOD     = 8'd1,
		RC_PRETAP  = 8'd2,
		RC_TAP1    = 8'd3,
		RC_TAP2    = 8'd4,
		RC_DC_GAIN = 8'd5,
		RC_EQ_CTRL = 8'd6,
		RC_APPLY   = 8'd7	// write starts apply, bit 0 reads busy
	} reconf_reg_e;

endpackage

`default_nettype wire

// File: source/phy_pma_pkg.sv
// pma package
// channel count, status sync depth and the analog settings of a channel
`default_nettype none

package phy_pma_pkg;

	////////////////////
	// channels and sync
	////////////////////
	localparam int NUM_CHANNELS = 4;
	localparam int CH_IDX_W     = 2;	// enough for NUM_CHANNELS
	localparam int SYNC_DEPTH   = 2;	// flops per synchronizer

	// block lock, data ready, hi ber per channel plus tx pll lock
	localparam int STATUS_W = 3*NUM_CHANNELS + 1;

	////////////////////
	// analog fields
	////////////////////
	typedef logic [2:0] vod_t;
	typedef logic [2:0] pretap_t;
	typedef logic [3:0] tap1_t;
	typedef logic [2:0] tap2_t;
	typedef logic [2:0] dc_gain_t;
	typedef logic [4:0] eq_ctrl_t;

	// legal maxima, writes above these saturate
	localparam int VOD_MAX     = 7;
	localparam int PRETAP_MAX  = 7;
	localparam int TAP1_MAX    = 15;
	localparam int TAP2_MAX    = 7;
	localparam int DC_GAIN_MAX = 4;	// field could hold 7
	localparam int EQ_CTRL_MAX = 16;	// field could hold 31

	typedef struct packed {
		vod_t     vod;	// msbs
		pretap_t  pretap;
		tap1_t    tap1;
		tap2_t    tap2;
		dc_gain_t dc_gain;
		eq_ctrl_t eq_ctrl;	// lsbs
	} pma_settings_t;

	localparam int SETTINGS_W = $bits(pma_settings_t);	// 21

	// power-up analog defaults of every channel
	localparam pma_settings_t RESET_SETTINGS = '{
		vod: 3'd1, pretap: 3'd0, tap1: 4'd5, tap2: 3'd0, dc_gain: 3'd0, eq_ctrl: 5'd14
	};

	////////////////////
	// apply timing
	////////////////////
	localparam int APPLY_CYCLES = 16;	// busy time of one apply
	localparam int APPLY_CNT_W  = $clog2(APPLY_CYCLES);

	typedef enum logic {
		APPLY_IDLE,
		APPLY_BUSY
	} apply_state_e;

endpackage

`default_nettype wire

// File: source/mgmt_slave_if.sv
// management slave bus
// one decoded request/response path from the decoder to a single slave
`timescale 1ns/1ns
`default_nettype none

interface mgmt_slave_if;
	import phy_mgmt_pkg::*;

	logic [SLAVE_ADDR_W-1:0] address;	// register offset in the slave
	logic                    read;	// one-cycle pulse
	logic                    write;	// one-cycle pulse
	logic [MGMT_DATA_W-1:0]  writedata;
	logic [MGMT_DATA_W-1:0]  readdata;	// registered by the slave, holds

	// decoder side
	modport master (
		output address,
		output read,
		output write,
		output writedata,
		input  readdata
	);

	// register block side
	modport slave (
		input  address,
		input  read,
		input  write,
		input  writedata,
		output readdata
	);

endinterface

`default_nettype wire

// File: source/mgmt_decoder.sv
// management decoder
// splits the port into csr and reconfig slaves, generates waitrequest
`timescale 1ns/1ns
`default_nettype none

module mgmt_decoder
(
	input  wire                                  phy_mgmt_clk,
	input  wire                                  rst,
	input  wire                                  phy_mgmt_read,
	input  wire                                  phy_mgmt_write,
	input  wire  [phy_mgmt_pkg::MGMT_ADDR_W-1:0] phy_mgmt_address,
	input  wire  [phy_mgmt_pkg::MGMT_DATA_W-1:0] phy_mgmt_writedata,
	input  wire                                  busy,	// reconfig apply running
	output logic [phy_mgmt_pkg::MGMT_DATA_W-1:0] phy_mgmt_readdata,
	output logic                                 phy_mgmt_waitrequest,
	mgmt_slave_if.master                         csr_bus,
	mgmt_slave_if.master                         reconf_bus
);
	import phy_mgmt_pkg::*;

	logic sel_reconf;	// address targets reconfig slave
	logic rd_wait_q;	// high in the second cycle of a read
	logic rd_go;	// first cycle of a read
	logic wr_stall;	// write held off by apply
	logic rd_sel_q;	// slave selection taken with the read

	assign sel_reconf = phy_mgmt_address[SEL_BIT];
	assign rd_go      = phy_mgmt_read && !rd_wait_q;
	assign wr_stall   = phy_mgmt_write && sel_reconf && busy;

	// reads wait one cycle, reconfig writes wait out busy
	assign phy_mgmt_waitrequest = rd_go || wr_stall;

	////////////////////
	// read wait flag
	////////////////////
	always_ff @(posedge phy_mgmt_clk)
	begin
		if (rst)
		begin
			rd_wait_q <= 1'b0;
			rd_sel_q  <= 1'b0;
		end
		else
		begin
			rd_wait_q <= rd_go;	// one cycle only, read ends next cycle
			if (rd_go)
				rd_sel_q <= sel_reconf;	// remember who answers
		end
	end

	////////////////////
	// slave requests
	////////////////////
	assign csr_bus.address    = phy_mgmt_address[SLAVE_ADDR_W-1:0];
	assign csr_bus.writedata  = phy_mgmt_writedata;
	assign csr_bus.read       = rd_go && !sel_reconf;
	assign csr_bus.write      = phy_mgmt_write && !sel_reconf;	// never stalled

	assign reconf_bus.address   = phy_mgmt_address[SLAVE_ADDR_W-1:0];
	assign reconf_bus.writedata = phy_mgmt_writedata;
	assign reconf_bus.read      = rd_go && sel_reconf;
	assign reconf_bus.write     = phy_mgmt_write && sel_reconf && !busy;	// withheld while busy

	// response path, valid in the cycle waitrequest drops
	assign phy_mgmt_readdata = rd_sel_q ? reconf_bus.readdata : csr_bus.readdata;

endmodule

`default_nettype wire

// File: source/status_csr.sv
// status csr
// syncs lock/ready/ber status, latches hi ber, holds digital reset controls
`timescale 1ns/1ns
`default_nettype none

module status_csr
(
	input  wire                                 phy_mgmt_clk,
	input  wire                                 rst,
	input  wire                                 tx_pll_locked,	// async
	input  wire  [phy_pma_pkg::NUM_CHANNELS-1:0] rx_block_lock,	// async
	input  wire  [phy_pma_pkg::NUM_CHANNELS-1:0] rx_data_ready,	// async
	input  wire  [phy_pma_pkg::NUM_CHANNELS-1:0] rx_hi_ber,	// async, may pulse
	mgmt_slave_if.slave                         bus,
	output logic                                pll_locked,
	output logic                                tx_ready,
	output logic                                rx_ready,
	output logic                                tx_digital_reset,
	output logic [phy_pma_pkg::NUM_CHANNELS-1:0] rx_digital_reset
);
	import phy_mgmt_pkg::*;
	import phy_pma_pkg::*;

	logic [STATUS_W-1:0]     status_raw;
	logic [STATUS_W-1:0]     sync_q [SYNC_DEPTH];	// stage 0 is metastable
	logic [STATUS_W-1:0]     status_s;
	logic [NUM_CHANNELS-1:0] block_lock_s;
	logic [NUM_CHANNELS-1:0] data_ready_s;
	logic [NUM_CHANNELS-1:0] hi_ber_s;
	logic                    pll_locked_s;
	logic [NUM_CHANNELS-1:0] hi_ber_q;	// sticky until read
	logic                    tx_rst_q;
	logic [NUM_CHANNELS-1:0] rx_rst_q;
	logic [MGMT_DATA_W-1:0]  ctrl_word;
	csr_reg_e                reg_sel;
	logic                    hi_ber_rd;

	assign reg_sel   = csr_reg_e'(bus.address);
	assign hi_ber_rd = bus.read && (reg_sel == CSR_HI_BER);

	////////////////////
	// synchronizers
	////////////////////
	assign status_raw = {tx_pll_locked, rx_hi_ber, rx_data_ready, rx_block_lock};

	always_ff @(posedge phy_mgmt_clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < SYNC_DEPTH; i++)
				sync_q[i] <= '0;
		end
		else
		begin
			sync_q[0] <= status_raw;
			for (int i = 1; i < SYNC_DEPTH; i++)
				sync_q[i] <= sync_q[i-1];	// shift toward output
		end
	end

	assign status_s     = sync_q[SYNC_DEPTH-1];
	assign block_lock_s = status_s[NUM_CHANNELS-1:0];
	assign data_ready_s = status_s[2*NUM_CHANNELS-1:NUM_CHANNELS];
	assign hi_ber_s     = status_s[3*NUM_CHANNELS-1:2*NUM_CHANNELS];
	assign pll_locked_s = status_s[STATUS_W-1];

	////////////////////
	// hi ber latch and resets
	////////////////////
	always_ff @(posedge phy_mgmt_clk)
	begin
		if (rst)
		begin
			hi_ber_q <= '0;
			tx_rst_q <= 1'b1;	// resets held until software releases
			rx_rst_q <= '1;
		end
		else
		begin
			hi_ber_q <= (hi_ber_rd ? '0 : hi_ber_q) | hi_ber_s;	// new set beats clear
			if (bus.write && (reg_sel == CSR_CONTROL))
			begin
				tx_rst_q <= bus.writedata[0];
				rx_rst_q <= bus.writedata[CTRL_RX_RESET_LSB +: NUM_CHANNELS];
			end
		end
	end

	always_comb
	begin
		ctrl_word    = '0;
		ctrl_word[0] = tx_rst_q;
		ctrl_word[CTRL_RX_RESET_LSB +: NUM_CHANNELS] = rx_rst_q;
	end

	// readiness straight from synced status, no extra flop
	assign pll_locked       = pll_locked_s;
	assign tx_ready         = pll_locked_s && !tx_rst_q;
	assign rx_ready         = (&data_ready_s) && !(|rx_rst_q) && tx_ready;
	assign tx_digital_reset = tx_rst_q;
	assign rx_digital_reset = rx_rst_q;

	////////////////////
	// read mux
	////////////////////
	always_ff @(posedge phy_mgmt_clk)
	begin
		if (bus.read)
		begin
			case (reg_sel)
				CSR_ID:         bus.readdata <= PHY_ID;
				CSR_BLOCK_LOCK: bus.readdata <= MGMT_DATA_W'(block_lock_s);
				CSR_DATA_READY: bus.readdata <= MGMT_DATA_W'(data_ready_s);
				CSR_HI_BER:     bus.readdata <= MGMT_DATA_W'(hi_ber_q);	// value before clear
				CSR_CONTROL:    bus.readdata <= ctrl_word;
				CSR_SUMMARY:    bus.readdata <= MGMT_DATA_W'({rx_ready, tx_ready, pll_locked_s});
				default:        bus.readdata <= '0;	// unmapped
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/pma_reconfig.sv
// pma reconfiguration
// stages clamped analog settings and applies them to one channel after a busy time
`timescale 1ns/1ns
`default_nettype none

module pma_reconfig
(
	input  wire         phy_mgmt_clk,
	input  wire         rst,
	mgmt_slave_if.slave bus,
	output logic        busy,	// apply in progress
	output logic [phy_pma_pkg::NUM_CHANNELS*phy_pma_pkg::SETTINGS_W-1:0] pma_settings
);
	import phy_mgmt_pkg::*;
	import phy_pma_pkg::*;

	reconf_reg_e            reg_sel;
	pma_settings_t          stage_q;	// staging set, shared by all channels
	pma_settings_t          active_q [NUM_CHANNELS];	// settings in use
	logic [CH_IDX_W-1:0]    ch_sel_q;
	logic [CH_IDX_W-1:0]    apply_ch_q;	// channel taken at apply
	apply_state_e           state_q;
	logic [APPLY_CNT_W-1:0] cnt_q;
	logic                   apply_go;
	logic                   apply_done;

	assign reg_sel    = reconf_reg_e'(bus.address);
	assign apply_go   = bus.write && (reg_sel == RC_APPLY) && (state_q == APPLY_IDLE);
	assign apply_done = (state_q == APPLY_BUSY) && (cnt_q == APPLY_CNT_W'(APPLY_CYCLES - 1));
	assign busy       = (state_q == APPLY_BUSY);

	////////////////////
	// staging registers
	////////////////////
	always_ff @(posedge phy_mgmt_clk)
	begin
		if (rst)
		begin
			stage_q  <= RESET_SETTINGS;
			ch_sel_q <= '0;
		end
		else if (bus.write)
		begin
			case (reg_sel)	// each field saturates at its max
				RC_CHANNEL: ch_sel_q <= bus.writedata[CH_IDX_W-1:0];
				RC_VOD:     stage_q.vod <= (bus.writedata > VOD_MAX) ?
						vod_t'(VOD_MAX) : vod_t'(bus.writedata);
				RC_PRETAP:  stage_q.pretap <= (bus.writedata > PRETAP_MAX) ?
						pretap_t'(PRETAP_MAX) : pretap_t'(bus.writedata);
				RC_TAP1:    stage_q.tap1 <= (bus.writedata > TAP1_MAX) ?
						tap1_t'(TAP1_MAX) : tap1_t'(bus.writedata);
				RC_TAP2:    stage_q.tap2 <= (bus.writedata > TAP2_MAX) ?
						tap2_t'(TAP2_MAX) : tap2_t'(bus.writedata);
				RC_DC_GAIN: stage_q.dc_gain <= (bus.writedata > DC_GAIN_MAX) ?
						dc_gain_t'(DC_GAIN_MAX) : dc_gain_t'(bus.writedata);
				RC_EQ_CTRL: stage_q.eq_ctrl <= (bus.writedata > EQ_CTRL_MAX) ?
						eq_ctrl_t'(EQ_CTRL_MAX) : eq_ctrl_t'(bus.writedata);
				default: ;	// apply handled by the fsm
			endcase
		end
	end

	////////////////////
	// apply fsm
	////////////////////
	always_ff @(posedge phy_mgmt_clk)
	begin
		if (rst)
		begin
			state_q    <= APPLY_IDLE;
			cnt_q      <= '0;
			apply_ch_q <= '0;
		end
		else
		begin
			case (state_q)
				APPLY_IDLE:
				begin
					if (apply_go)
					begin
						state_q    <= APPLY_BUSY;	// busy from next cycle
						cnt_q      <= '0;
						apply_ch_q <= ch_sel_q;
					end
				end
				APPLY_BUSY:
				begin
					if (apply_done)
						state_q <= APPLY_IDLE;
					else
						cnt_q <= cnt_q + 1'b1;
				end
				default: state_q <= APPLY_IDLE;
			endcase
		end
	end

	// active sets, target changes on the edge busy falls
	always_ff @(posedge phy_mgmt_clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_CHANNELS; i++)
				active_q[i] <= RESET_SETTINGS;
		end
		else if (apply_done)
			active_q[apply_ch_q] <= stage_q;
	end

	always_comb
	begin
		for (int i = 0; i < NUM_CHANNELS; i++)
			pma_settings[i*SETTINGS_W +: SETTINGS_W] = active_q[i];	// ch 0 in lsbs
	end

	////////////////////
	// read mux
	////////////////////
	always_ff @(posedge phy_mgmt_clk)
	begin
		if (bus.read)
		begin
			case (reg_sel)
				RC_CHANNEL: bus.readdata <= MGMT_DATA_W'(ch_sel_q);
				RC_VOD:     bus.readdata <= MGMT_DATA_W'(stage_q.vod);
				RC_PRETAP:  bus.readdata <= MGMT_DATA_W'(stage_q.pretap);
				RC_TAP1:    bus.readdata <= MGMT_DATA_W'(stage_q.tap1);
				RC_TAP2:    bus.readdata <= MGMT_DATA_W'(stage_q.tap2);
				RC_DC_GAIN: bus.readdata <= MGMT_DATA_W'(stage_q.dc_gain);
				RC_EQ_CTRL: bus.readdata <= MGMT_DATA_W'(stage_q.eq_ctrl);
				RC_APPLY:   bus.readdata <= MGMT_DATA_W'(busy);	// status in bit 0
				default:    bus.readdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/phy_mgmt_top.sv
// phy management top
// management port, status csr and pma reconfiguration of a multi-channel 10gbase-r phy
`timescale 1ns/1ns
`default_nettype none

module phy_mgmt_top
(
	input  wire                                          phy_mgmt_clk,
	input  wire                                          rst,
	input  wire                                          phy_mgmt_read,
	input  wire                                          phy_mgmt_write,
	input  wire  [phy_mgmt_pkg::MGMT_ADDR_W-1:0]         phy_mgmt_address,
	input  wire  [phy_mgmt_pkg::MGMT_DATA_W-1:0]         phy_mgmt_writedata,
	output wire  [phy_mgmt_pkg::MGMT_DATA_W-1:0]         phy_mgmt_readdata,
	output wire                                          phy_mgmt_waitrequest,
	input  wire                                          tx_pll_locked,
	input  wire  [phy_pma_pkg::NUM_CHANNELS-1:0]         rx_block_lock,
	input  wire  [phy_pma_pkg::NUM_CHANNELS-1:0]         rx_data_ready,
	input  wire  [phy_pma_pkg::NUM_CHANNELS-1:0]         rx_hi_ber,
	output wire                                          pll_locked,
	output wire                                          tx_ready,
	output wire                                          rx_ready,
	output wire                                          tx_digital_reset,
	output wire  [phy_pma_pkg::NUM_CHANNELS-1:0]         rx_digital_reset,
	output wire  [phy_pma_pkg::NUM_CHANNELS*phy_pma_pkg::SETTINGS_W-1:0] pma_settings,
	output wire                                          reconfig_busy
);

	mgmt_slave_if csr_bus ();	// low half of the address map
	mgmt_slave_if reconf_bus ();	// high half, SEL_BIT set

	////////////////////
	// port decoder
	////////////////////
	mgmt_decoder u_decoder (
		.phy_mgmt_clk         (phy_mgmt_clk),
		.rst                  (rst),
		.phy_mgmt_read        (phy_mgmt_read),
		.phy_mgmt_write       (phy_mgmt_write),
		.phy_mgmt_address     (phy_mgmt_address),
		.phy_mgmt_writedata   (phy_mgmt_writedata),
		.busy                 (reconfig_busy),	// back-pressure source
		.phy_mgmt_readdata    (phy_mgmt_readdata),
		.phy_mgmt_waitrequest (phy_mgmt_waitrequest),
		.csr_bus              (csr_bus.master),
		.reconf_bus           (reconf_bus.master)
	);

	////////////////////
	// slaves
	////////////////////
	status_csr u_status_csr (
		.phy_mgmt_clk     (phy_mgmt_clk),
		.rst              (rst),
		.tx_pll_locked    (tx_pll_locked),
		.rx_block_lock    (rx_block_lock),
		.rx_data_ready    (rx_data_ready),
		.rx_hi_ber        (rx_hi_ber),
		.bus              (csr_bus.slave),
		.pll_locked       (pll_locked),
		.tx_ready         (tx_ready),
		.rx_ready         (rx_ready),
		.tx_digital_reset (tx_digital_reset),
		.rx_digital_reset (rx_digital_reset)
	);

	pma_reconfig u_pma_reconfig (
		.phy_mgmt_clk (phy_mgmt_clk),
		.rst          (rst),
		.bus          (reconf_bus.slave),
		.busy         (reconfig_busy),
		.pma_settings (pma_settings)	// flat, channel 0 in lsbs
	);

endmodule

`default_nettype wire

// File: verification/phy_mgmt_tb.sv
// phy management testbench
// table-driven bus reads, writes and pin checks against the management top
`timescale 1ns/1ns
`default_nettype none

module phy_mgmt_tb;
	import phy_mgmt_pkg::*;
	import phy_pma_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int QTR        = CLK_PERIOD / 4;	// sample point after falling edge
	localparam logic [8:0] RC_BASE = 9'h100;	// reconfig half of the map

	typedef enum {OP_READ, OP_WRITE, OP_SETTLE, OP_PINS, OP_APPLY, OP_SLICE} op_e;

	logic        clk;
	logic        rst;
	logic        phy_mgmt_read;
	logic        phy_mgmt_write;
	logic [8:0]  phy_mgmt_address;
	logic [31:0] phy_mgmt_writedata;
	wire  [31:0] phy_mgmt_readdata;
	wire         phy_mgmt_waitrequest;
	logic        tx_pll_locked;
	logic [3:0]  rx_block_lock;
	logic [3:0]  rx_data_ready;
	logic [3:0]  rx_hi_ber;
	wire         pll_locked;
	wire         tx_ready;
	wire         rx_ready;
	wire         tx_digital_reset;
	wire  [3:0]  rx_digital_reset;
	wire  [NUM_CHANNELS*SETTINGS_W-1:0] pma_settings;
	wire         reconfig_busy;

	// test table, one entry per index
	string       t_name [$];
	op_e         t_op [$];
	logic [8:0]  t_addr [$];
	logic [31:0] t_wdata [$];
	logic [12:0] t_stat [$];	// {pll, hi_ber, data_ready, block_lock}
	logic [31:0] t_exp [$];

	logic [31:0] rand_state;
	logic        table_ready;
	int          err_cnt;
	int          check_cnt;

	phy_mgmt_top UUT (
		.phy_mgmt_clk         (clk),
		.rst                  (rst),
		.phy_mgmt_read        (phy_mgmt_read),
		.phy_mgmt_write       (phy_mgmt_write),
		.phy_mgmt_address     (phy_mgmt_address),
		.phy_mgmt_writedata   (phy_mgmt_writedata),
		.phy_mgmt_readdata    (phy_mgmt_readdata),
		.phy_mgmt_waitrequest (phy_mgmt_waitrequest),
		.tx_pll_locked        (tx_pll_locked),
		.rx_block_lock        (rx_block_lock),
		.rx_data_ready        (rx_data_ready),
		.rx_hi_ber            (rx_hi_ber),
		.pll_locked           (pll_locked),
		.tx_ready             (tx_ready),
		.rx_ready             (rx_ready),
		.tx_digital_reset     (tx_digital_reset),
		.rx_digital_reset     (rx_digital_reset),
		.pma_settings         (pma_settings),
		.reconfig_busy        (reconfig_busy)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	////////////////////
	// helpers
	////////////////////
	function automatic logic [31:0] lcg_step();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic logic [12:0] status_word(input logic pll, input logic [3:0] bl,
		input logic [3:0] dr, input logic [3:0] ber);
		return {pll, ber, dr, bl};
	endfunction

	function automatic int field_limit(input int f);
		case (f)	// legal maxima per staging offset
			0:       return VOD_MAX;
			1:       return PRETAP_MAX;
			2:       return TAP1_MAX;
			3:       return TAP2_MAX;
			4:       return DC_GAIN_MAX;
			default: return EQ_CTRL_MAX;
		endcase
	endfunction

	function automatic string field_label(input int f);
		case (f)
			0:       return "vod";
			1:       return "pretap";
			2:       return "tap1";
			3:       return "tap2";
			4:       return "dc_gain";
			default: return "eq_ctrl";
		endcase
	endfunction

	// anything above the limit reads back as the limit
	function automatic logic [31:0] saturate(input logic [31:0] value, input int limit);
		return (value > 32'(limit)) ? 32'(limit) : value;
	endfunction

	task automatic add_entry(input string name, input op_e op, input logic [8:0] addr,
		input logic [31:0] wdata, input logic [12:0] stat, input logic [31:0] exp);
		t_name.push_back(name);
		t_op.push_back(op);
		t_addr.push_back(addr);
		t_wdata.push_back(wdata);
		t_stat.push_back(stat);
		t_exp.push_back(exp);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_cnt++;
		assert (actual === expected)
		else
		begin
			err_cnt++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic drive_status(input logic [12:0] stat);
		tx_pll_locked = stat[12];
		rx_hi_ber     = stat[11:8];
		rx_data_ready = stat[7:4];
		rx_block_lock = stat[3:0];
	endtask

	////////////////////
	// bus tasks
	////////////////////
	// called on a falling edge, returns on the falling edge after the transfer
	task automatic bus_read(input logic [8:0] addr, output logic [31:0] data, output int waits);
		waits = 0;
		phy_mgmt_address = addr;
		phy_mgmt_read    = 1'b1;
		#(QTR);
		while (phy_mgmt_waitrequest)
		begin
			waits++;
			@(negedge clk);
			#(QTR);
		end
		data = phy_mgmt_readdata;	// valid while waitrequest low
		@(negedge clk);
		phy_mgmt_read = 1'b0;
	endtask

	task automatic bus_write(input logic [8:0] addr, input logic [31:0] data, output int waits);
		waits = 0;
		phy_mgmt_address   = addr;
		phy_mgmt_writedata = data;
		phy_mgmt_write     = 1'b1;
		forever
		begin
			#(QTR);
			if (addr[8])
			begin
				assert (phy_mgmt_waitrequest == reconfig_busy)
				else
				begin
					err_cnt++;
					$display("ERROR: waitrequest did not follow reconfig busy on a write");
				end
			end
			if (!phy_mgmt_waitrequest)
				break;
			waits++;	// stalled by apply
			@(negedge clk);
		end
		@(negedge clk);
		phy_mgmt_write = 1'b0;
	endtask

	////////////////////
	// test table
	////////////////////
	task automatic build_table();
		logic [12:0]   idle_st;
		logic [12:0]   ready_st;
		logic [31:0]   r;
		logic [8:0]    a;
		int            staged [6];
		pma_settings_t exp_stage;
		idle_st  = status_word(1'b0, 4'h0, 4'h0, 4'h0);
		ready_st = status_word(1'b1, 4'hF, 4'hF, 4'h0);

		add_entry("reset_pins", OP_PINS, 9'h000, 0, idle_st, 32'hF8);
		add_entry("read_id", OP_READ, 9'h000, 0, idle_st, PHY_ID);
		add_entry("read_unmapped", OP_READ, 9'h020, 0, idle_st, 0);

		// sync of block lock and data ready
		add_entry("settle_lock", OP_SETTLE, 0, 0, status_word(1'b0, 4'hA, 4'h5, 4'h0), 0);
		add_entry("read_block_lock", OP_READ, 9'h001, 0,
			status_word(1'b0, 4'hA, 4'h5, 4'h0), 32'hA);
		add_entry("read_data_ready", OP_READ, 9'h002, 0,
			status_word(1'b0, 4'hA, 4'h5, 4'h0), 32'h5);

		// short hi ber pulse on channel 2
		add_entry("ber_pulse", OP_SETTLE, 0, 0, status_word(1'b0, 4'h0, 4'h0, 4'h4), 0);
		add_entry("ber_gone", OP_SETTLE, 0, 0, idle_st, 0);
		add_entry("read_hi_ber", OP_READ, 9'h003, 0, idle_st, 32'h4);
		add_entry("read_hi_ber_clr", OP_READ, 9'h003, 0, idle_st, 0);

		// resets and readiness
		add_entry("settle_ready", OP_SETTLE, 0, 0, ready_st, 0);
		add_entry("pins_held", OP_PINS, 0, 0, ready_st, 32'hF9);
		add_entry("release_resets", OP_WRITE, 9'h004, 0, ready_st, 0);
		add_entry("pins_released", OP_PINS, 0, 0, ready_st, 32'h07);
		add_entry("read_summary", OP_READ, 9'h005, 0, ready_st, 32'h7);
		add_entry("hold_rx1", OP_WRITE, 9'h004, 32'h1 << (CTRL_RX_RESET_LSB + 1), ready_st, 0);
		add_entry("pins_rx1_held", OP_PINS, 0, 0, ready_st, 32'h23);
		add_entry("read_control", OP_READ, 9'h004, 0, ready_st, 32'h200);
		add_entry("read_summary_rx1", OP_READ, 9'h005, 0, ready_st, 32'h3);

		// clamping, last random write of each field stays staged
		rand_state = 32'h9608_f744;
		for (int f = 0; f < 6; f++)
		begin
			a = RC_BASE | 9'(f + 1);
			r = (lcg_step() >> 16) & 32'h1F;
			add_entry({field_label(f), "_rand"}, OP_WRITE, a, r, ready_st, 0);
			add_entry({field_label(f), "_rand_rd"}, OP_READ, a, 0, ready_st,
				saturate(r, field_limit(f)));
			r = 32'h8000_0000 | lcg_step();	// far out of range
			add_entry({field_label(f), "_oor"}, OP_WRITE, a, r, ready_st, 0);
			add_entry({field_label(f), "_oor_rd"}, OP_READ, a, 0, ready_st,
				saturate(r, field_limit(f)));
			r = (lcg_step() >> 8) & 32'h1F;
			staged[f] = saturate(r, field_limit(f));
			add_entry({field_label(f), "_final"}, OP_WRITE, a, r, ready_st, 0);
			add_entry({field_label(f), "_final_rd"}, OP_READ, a, 0, ready_st, staged[f]);
		end

		exp_stage.vod     = 3'(staged[0]);
		exp_stage.pretap  = 3'(staged[1]);
		exp_stage.tap1    = 4'(staged[2]);
		exp_stage.tap2    = 3'(staged[3]);
		exp_stage.dc_gain = 3'(staged[4]);
		exp_stage.eq_ctrl = 5'(staged[5]);

		// apply to channel 2, the stalled write moves the select to 3
		add_entry("select_ch2", OP_WRITE, RC_BASE, 32'd2, ready_st, 0);
		add_entry("apply_stall", OP_APPLY, RC_BASE | 9'h007, 32'd3, ready_st, APPLY_CYCLES - 1);
		add_entry("read_apply_idle", OP_READ, RC_BASE | 9'h007, 0, ready_st, 0);
		add_entry("read_channel", OP_READ, RC_BASE, 0, ready_st, 32'd3);
		add_entry("slice_ch0", OP_SLICE, 9'd0, 0, ready_st, 32'(RESET_SETTINGS));
		add_entry("slice_ch1", OP_SLICE, 9'd1, 0, ready_st, 32'(RESET_SETTINGS));
		add_entry("slice_ch2", OP_SLICE, 9'd2, 0, ready_st, 32'(exp_stage));
		add_entry("slice_ch3", OP_SLICE, 9'd3, 0, ready_st, 32'(RESET_SETTINGS));
	endtask

	////////////////////
	// main sequence
	////////////////////
	initial
	begin
		logic [31:0] rdata;
		int          waits;
		clk                = 1'b0;
		rst                = 1'b1;
		phy_mgmt_read      = 1'b0;
		phy_mgmt_write     = 1'b0;
		phy_mgmt_address   = '0;
		phy_mgmt_writedata = '0;
		drive_status('0);
		err_cnt     = 0;
		check_cnt   = 0;
		table_ready = 1'b0;
		build_table();
		table_ready = 1'b1;

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < t_name.size(); i++)
		begin
			@(negedge clk);
			drive_status(t_stat[i]);
			case (t_op[i])
				OP_READ:
				begin
					bus_read(t_addr[i], rdata, waits);
					check_value(t_name[i], t_exp[i], rdata);
					check_value({t_name[i], "_latency"}, 32'd1, waits);	// one wait cycle
				end
				OP_WRITE:
				begin
					bus_write(t_addr[i], t_wdata[i], waits);
					check_value({t_name[i], "_stall"}, 32'd0, waits);
				end
				OP_SETTLE:
					repeat (SYNC_DEPTH + 2) @(negedge clk);
				OP_PINS:
				begin
					#(QTR);
					check_value(t_name[i], t_exp[i], {24'd0, rx_digital_reset,
						tx_digital_reset, rx_ready, tx_ready, pll_locked});
				end
				OP_APPLY:
				begin
					bus_write(t_addr[i], 32'd1, waits);
					#(QTR);
					check_value({t_name[i], "_busy"}, 32'd1, reconfig_busy);
					@(negedge clk);
					bus_write(RC_BASE, t_wdata[i], waits);	// held off until busy falls
					check_value(t_name[i], t_exp[i], waits);
				end
				OP_SLICE:
				begin
					#(QTR);
					check_value(t_name[i], t_exp[i],
						32'(pma_settings[t_addr[i]*SETTINGS_W +: SETTINGS_W]));
				end
				default: ;
			endcase
		end

		$display("%0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// watchdog, scaled by table length
	initial
	begin
		int limit;
		wait (table_ready);
		limit = t_name.size() * (APPLY_CYCLES + 10) * CLK_PERIOD;
		#(limit);
		$display("ERROR: watchdog expired before the test table completed");
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
source/phy_mgmt_pkg.sv
source/phy_pma_pkg.sv
source/mgmt_slave_if.sv
source/mgmt_decoder.sv
source/status_csr.sv
source/pma_reconfig.sv
source/phy_mgmt_top.sv
verification/phy_mgmt_tb.sv
